// File: Bender.yml
package:
  name: riscv_core

sources:
  - hw/rv_pkg.sv
  - hw/fetch_unit.sv
  - hw/decode_read.sv
  - hw/execute.sv
  - hw/writeback_stage.sv
  - hw/riscv_core.sv
  - target: test
    files:
      - test/riscv_core_assert.sv
      - test/tb_riscv_core.sv

// File: files.f
hw/rv_pkg.sv
hw/fetch_unit.sv
hw/decode_read.sv
hw/execute.sv
hw/writeback_stage.sv
hw/riscv_core.sv
test/riscv_core_assert.sv
test/tb_riscv_core.sv

// File: hw/decode_read.sv
`timescale 1ns/1ns

module decode_read import rv_pkg::*; (
  input  logic     clk,
  input  logic     reset,
  input  logic     stall,
  input  logic     squash,
  input  instr_u   instr,
  input  logic     wb_we,
  input  reg_idx_t wb_rd,
  input  xlen_t    wb_data,
  output dx_t      dx
);

  xlen_t regs [32];
  ctrl_t ctrl;
  xlen_t imm;
  dx_t   dx_next;

  xlen_t i_imm;
  xlen_t s_imm;
  xlen_t b_imm;
  xlen_t u_imm;
  xlen_t j_imm;
  logic  csr_hit;

  // Register read with x0 hardwired to zero.
  // A write landing in the same cycle is passed straight through.
  function automatic xlen_t read_reg(reg_idx_t idx);
    if (idx == '0) begin
      return '0;
    end else if (wb_we && (wb_rd == idx)) begin
      return wb_data;
    end
    return regs[idx];
  endfunction

  // Maps funct3 to an ALU operation. alt selects sub or sra.
  function automatic alu_op_e alu_decode(logic [2:0] f3, logic alt);
    case (f3)
      3'b000:  return alt ? ALU_SUB : ALU_ADD;
      3'b001:  return ALU_SLL;
      3'b010:  return ALU_SLT;
      3'b011:  return ALU_SLTU;
      3'b100:  return ALU_XOR;
      3'b101:  return alt ? ALU_SRA : ALU_SRL;
      3'b110:  return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  // Immediates in every format, each read through its own view of the word.
  assign i_imm = {{20{instr.i_fmt.imm[11]}}, instr.i_fmt.imm};
  assign s_imm = {{20{instr.s_fmt.imm_hi[6]}}, instr.s_fmt.imm_hi, instr.s_fmt.imm_lo};
  assign b_imm = {{19{instr.b_fmt.imm_12}}, instr.b_fmt.imm_12, instr.b_fmt.imm_11,
                  instr.b_fmt.imm_10_5, instr.b_fmt.imm_4_1, 1'b0};
  // The U and J layouts cover the register fields, so they come from the R view.
  assign u_imm = {instr.r_fmt.funct7, instr.r_fmt.rs2, instr.r_fmt.rs1,
                  instr.r_fmt.funct3, 12'h000};
  assign j_imm = {{12{instr.r_fmt.funct7[6]}}, instr.r_fmt.rs1, instr.r_fmt.funct3,
                  instr.r_fmt.rs2[0], instr.r_fmt.funct7[5:0], instr.r_fmt.rs2[4:1], 1'b0};

  // Only csrrw and csrrwi on tohost are recognised.
  assign csr_hit = (instr.i_fmt.imm == CSR_TOHOST) && (instr.i_fmt.funct3[1:0] == 2'b01);

  always_comb begin
    ctrl        = '0;
    ctrl.funct3 = instr.i_fmt.funct3;
    imm         = i_imm;
    case (instr.r_fmt.opcode)
      OP_LUI: begin
        ctrl.reg_we    = 1'b1;
        ctrl.b_sel_imm = 1'b1;
        ctrl.alu_op    = ALU_PASS_B;
        imm            = u_imm;
      end
      OP_AUIPC: begin
        ctrl.reg_we    = 1'b1;
        ctrl.a_sel_pc  = 1'b1;
        ctrl.b_sel_imm = 1'b1;
        imm            = u_imm;
      end
      // The ALU forms the jump target, execute supplies the link value.
      OP_JAL: begin
        ctrl.reg_we    = 1'b1;
        ctrl.is_jump   = 1'b1;
        ctrl.a_sel_pc  = 1'b1;
        ctrl.b_sel_imm = 1'b1;
        imm            = j_imm;
      end
      OP_JALR: begin
        ctrl.reg_we    = 1'b1;
        ctrl.is_jump   = 1'b1;
        ctrl.b_sel_imm = 1'b1;
      end
      OP_BRANCH: begin
        ctrl.is_branch = 1'b1;
        ctrl.a_sel_pc  = 1'b1;
        ctrl.b_sel_imm = 1'b1;
        imm            = b_imm;
      end
      OP_LOAD: begin
        ctrl.reg_we    = 1'b1;
        ctrl.mem_re    = 1'b1;
        ctrl.b_sel_imm = 1'b1;
      end
      OP_STORE: begin
        ctrl.mem_we    = 1'b1;
        ctrl.b_sel_imm = 1'b1;
        imm            = s_imm;
      end
      // Only the shift right immediate takes the alternate form, addi has no sub.
      OP_IMM: begin
        ctrl.reg_we    = 1'b1;
        ctrl.b_sel_imm = 1'b1;
        ctrl.alu_op    = alu_decode(instr.i_fmt.funct3,
                                    instr.r_fmt.funct7[5] && (instr.i_fmt.funct3 == 3'b101));
      end
      OP_REG: begin
        ctrl.reg_we = 1'b1;
        ctrl.alu_op = alu_decode(instr.r_fmt.funct3, instr.r_fmt.funct7[5]);
      end
      // csrrw passes rs1 plus zero, csrrwi passes the zero-extended rs1 field.
      // The old tohost value is not returned, so rd is left unwritten.
      OP_SYSTEM: begin
        ctrl.csr_we    = csr_hit;
        ctrl.b_sel_imm = 1'b1;
        if (instr.i_fmt.funct3[2]) begin
          ctrl.alu_op = ALU_PASS_B;
          imm         = {27'd0, instr.r_fmt.rs1};
        end else begin
          imm = '0;
        end
      end
      default: begin
        ctrl = '0;
      end
    endcase
  end

  always_comb begin
    dx_next.ctrl  = squash ? '0 : ctrl;
    dx_next.rs1   = instr.r_fmt.rs1;
    dx_next.rs2   = instr.r_fmt.rs2;
    dx_next.rd    = instr.r_fmt.rd;
    dx_next.reg_a = read_reg(instr.r_fmt.rs1);
    dx_next.reg_b = read_reg(instr.r_fmt.rs2);
    dx_next.imm   = imm;
  end

  // Writes to x0 are dropped.
  always_ff @(posedge clk) begin
    if (wb_we && !stall && (wb_rd != '0)) begin
      regs[wb_rd] <= wb_data;
    end
  end

  // Only the controls are reset; the operands are don't-care in a bubble.
  always_ff @(posedge clk) begin
    if (reset) begin
      dx.ctrl <= '0;
    end else if (!stall) begin
      dx <= dx_next;
    end
  end

endmodule

// File: hw/execute.sv
`timescale 1ns/1ns

module execute import rv_pkg::*; (
  input  dx_t       dx,
  input  xlen_t     pc,
  input  logic      wb_we,
  input  reg_idx_t  wb_rd,
  input  xlen_t     wb_data,
  output logic      redirect,
  output xlen_t     target,
  output dmem_req_t dmem,
  output xw_t       xw
);

  xlen_t fwd_a;
  xlen_t fwd_b;
  xlen_t op_a;
  xlen_t op_b;
  xlen_t alu_out;
  logic  taken;

  // The instruction in writeback is one older than this one.
  // Anything older has already reached the register file.
  assign fwd_a = (wb_we && (wb_rd != '0) && (wb_rd == dx.rs1)) ? wb_data : dx.reg_a;
  assign fwd_b = (wb_we && (wb_rd != '0) && (wb_rd == dx.rs2)) ? wb_data : dx.reg_b;

  assign op_a = dx.ctrl.a_sel_pc ? pc : fwd_a;
  assign op_b = dx.ctrl.b_sel_imm ? dx.imm : fwd_b;

  always_comb begin
    case (dx.ctrl.alu_op)
      ALU_ADD:    alu_out = op_a + op_b;
      ALU_SUB:    alu_out = op_a - op_b;
      ALU_AND:    alu_out = op_a & op_b;
      ALU_OR:     alu_out = op_a | op_b;
      ALU_XOR:    alu_out = op_a ^ op_b;
      ALU_SLT:    alu_out = {31'd0, $signed(op_a) < $signed(op_b)};
      ALU_SLTU:   alu_out = {31'd0, op_a < op_b};
      ALU_SLL:    alu_out = op_a << op_b[4:0];
      ALU_SRL:    alu_out = op_a >> op_b[4:0];
      ALU_SRA:    alu_out = $signed(op_a) >>> op_b[4:0];
      ALU_PASS_B: alu_out = op_b;
      default:    alu_out = op_a + op_b;
    endcase
  end

  // Branches compare the register operands, never the immediate.
  always_comb begin
    case (dx.ctrl.funct3)
      3'b000:  taken = (fwd_a == fwd_b);
      3'b001:  taken = (fwd_a != fwd_b);
      3'b100:  taken = ($signed(fwd_a) < $signed(fwd_b));
      3'b101:  taken = ($signed(fwd_a) >= $signed(fwd_b));
      3'b110:  taken = (fwd_a < fwd_b);
      3'b111:  taken = (fwd_a >= fwd_b);
      default: taken = 1'b0;
    endcase
  end

  assign redirect = dx.ctrl.is_jump || (dx.ctrl.is_branch && taken);
  // Bit zero is cleared as jalr requires; other targets are already even.
  assign target = {alu_out[31:1], 1'b0};

  // Word access only, so a store enables all four byte lanes.
  assign dmem.addr = alu_out;
  assign dmem.we   = {4{dx.ctrl.mem_we}};
  assign dmem.re   = dx.ctrl.mem_re;
  assign dmem.din  = fwd_b;

  assign xw.reg_we = dx.ctrl.reg_we;
  assign xw.mem_re = dx.ctrl.mem_re;
  assign xw.csr_we = dx.ctrl.csr_we;
  assign xw.rd     = dx.rd;
  // Jumps write the link address instead of the computed target.
  assign xw.result = dx.ctrl.is_jump ? pc + 32'd4 : alu_out;

endmodule

// File: hw/fetch_unit.sv
`timescale 1ns/1ns

module fetch_unit import rv_pkg::*; (
  input  logic  clk,
  input  logic  reset,
  input  logic  stall,
  input  logic  redirect,
  input  xlen_t target,
  output xlen_t next_pc,
  output xlen_t pc_ex
);

  // Address currently presented to the instruction memory.
  xlen_t pc_q;
  // PC of the word now sitting in decode.
  xlen_t pc_dec;
  // PC of the instruction now in execute.
  xlen_t pc_exe;

  // A redirect from execute lands on the fetch address at the next edge.
  // The two words already requested behind the jump are squashed downstream.
  always_ff @(posedge clk) begin
    if (reset) begin
      pc_q <= PC_RESET;
    end else if (!stall) begin
      if (redirect) begin
        pc_q <= target;
      end else begin
        pc_q <= pc_q + 32'd4;
      end
    end
  end

  // The memory returns the word one cycle after its address, so the PC
  // is delayed once to match decode and once more to match execute.
  always_ff @(posedge clk) begin
    if (!stall) begin
      pc_dec <= pc_q;
      pc_exe <= pc_dec;
    end
  end

  assign next_pc = pc_q;
  assign pc_ex   = pc_exe;

endmodule

// File: hw/riscv_core.sv
`timescale 1ns/1ns

module riscv_core import rv_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  output xlen_t     icache_addr,
  output logic      icache_re,
  input  xlen_t     icache_dout,
  output dmem_req_t dmem,
  input  xlen_t     dcache_dout,
  input  logic      stall,
  output xlen_t     csr
);

  logic     redirect;
  xlen_t    target;
  xlen_t    pc_ex;
  logic     squash;
  dx_t      dx;
  xw_t      xw;
  logic     wb_we;
  reg_idx_t wb_rd;
  xlen_t    wb_data;

  // The instruction memory is read every cycle once out of reset.
  assign icache_re = ~reset;

  fetch_unit i_fetch (
    .clk      (clk),
    .reset    (reset),
    .stall    (stall),
    .redirect (redirect),
    .target   (target),
    .next_pc  (icache_addr),
    .pc_ex    (pc_ex)
  );

  decode_read i_decode (
    .clk     (clk),
    .reset   (reset),
    .stall   (stall),
    .squash  (squash),
    .instr   (instr_u'(icache_dout)),
    .wb_we   (wb_we),
    .wb_rd   (wb_rd),
    .wb_data (wb_data),
    .dx      (dx)
  );

  execute i_execute (
    .dx       (dx),
    .pc       (pc_ex),
    .wb_we    (wb_we),
    .wb_rd    (wb_rd),
    .wb_data  (wb_data),
    .redirect (redirect),
    .target   (target),
    .dmem     (dmem),
    .xw       (xw)
  );

  // Writeback also feeds the register file and the forwarding paths.
  writeback_stage i_writeback (
    .clk         (clk),
    .reset       (reset),
    .stall       (stall),
    .xw_in       (xw),
    .redirect    (redirect),
    .dcache_dout (dcache_dout),
    .squash      (squash),
    .wb_we       (wb_we),
    .wb_rd       (wb_rd),
    .wb_data     (wb_data),
    .csr         (csr)
  );

endmodule

// File: hw/rv_pkg.sv
package rv_pkg;

  typedef logic [31:0] xlen_t;
  typedef logic [4:0]  reg_idx_t;

  // Fetch starts at address zero out of reset.
  localparam xlen_t       PC_RESET   = 32'h0000_0000;
  // The only CSR the core implements is the testbench mailbox.
  localparam logic [11:0] CSR_TOHOST = 12'h51e;

  localparam logic [6:0] OP_LUI    = 7'b0110111;
  localparam logic [6:0] OP_AUIPC  = 7'b0010111;
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_JALR   = 7'b1100111;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_IMM    = 7'b0010011;
  localparam logic [6:0] OP_REG    = 7'b0110011;
  localparam logic [6:0] OP_SYSTEM = 7'b1110011;

  // ALU_ADD must stay at zero, since a cleared control word means add.
  typedef enum logic [3:0] {
    ALU_ADD    = 4'd0,
    ALU_SUB    = 4'd1,
    ALU_AND    = 4'd2,
    ALU_OR     = 4'd3,
    ALU_XOR    = 4'd4,
    ALU_SLT    = 4'd5,
    ALU_SLTU   = 4'd6,
    ALU_SLL    = 4'd7,
    ALU_SRL    = 4'd8,
    ALU_SRA    = 4'd9,
    ALU_PASS_B = 4'd10
  } alu_op_e;

  typedef struct packed {
    logic [6:0] funct7;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    reg_idx_t   rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;
    reg_idx_t    rs1;
    logic [2:0]  funct3;
    reg_idx_t    rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } s_fmt_t;

  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [6:0] opcode;
  } b_fmt_t;

  // One instruction word seen through each encoding format.
  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    s_fmt_t s_fmt;
    b_fmt_t b_fmt;
  } instr_u;

  typedef struct packed {
    logic       reg_we;
    logic       mem_we;
    logic       mem_re;
    logic       csr_we;
    logic       is_jump;
    logic       is_branch;
    logic       a_sel_pc;
    logic       b_sel_imm;
    alu_op_e    alu_op;
    logic [2:0] funct3;
  } ctrl_t;

  typedef struct packed {
    ctrl_t    ctrl;
    reg_idx_t rs1;
    reg_idx_t rs2;
    reg_idx_t rd;
    xlen_t    reg_a;
    xlen_t    reg_b;
    xlen_t    imm;
  } dx_t;

  typedef struct packed {
    logic     reg_we;
    logic     mem_re;
    logic     csr_we;
    reg_idx_t rd;
    xlen_t    result;
  } xw_t;

  typedef struct packed {
    xlen_t      addr;
    logic [3:0] we;
    logic       re;
    xlen_t      din;
  } dmem_req_t;

endpackage

// File: hw/writeback_stage.sv
`timescale 1ns/1ns

module writeback_stage import rv_pkg::*; (
  input  logic     clk,
  input  logic     reset,
  input  logic     stall,
  input  xw_t      xw_in,
  input  logic     redirect,
  input  xlen_t    dcache_dout,
  output logic     squash,
  output logic     wb_we,
  output reg_idx_t wb_rd,
  output xlen_t    wb_data,
  output xlen_t    csr
);

  xw_t  xw_q;
  xw_t  xw_next;
  // Set for the cycle after a redirect and for the first cycle out of reset.
  logic pause_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      pause_q <= 1'b1;
    end else if (!stall) begin
      pause_q <= redirect;
    end
  end

  // The word in decode is dead during the redirect cycle itself, and the
  // word fetched just before the new address arrives one cycle later.
  // Covering both cycles keeps either from reaching execute.
  assign squash = redirect | pause_q;

  // The redirecting instruction itself must still retire here.
  // Only the slot behind it is dropped.
  always_comb begin
    xw_next = xw_in;
    if (pause_q) begin
      xw_next.reg_we = 1'b0;
      xw_next.mem_re = 1'b0;
      xw_next.csr_we = 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      xw_q.reg_we <= 1'b0;
      xw_q.mem_re <= 1'b0;
      xw_q.csr_we <= 1'b0;
    end else if (!stall) begin
      xw_q <= xw_next;
    end
  end

  // Load data comes back from the synchronous memory in this cycle.
  assign wb_we   = xw_q.reg_we;
  assign wb_rd   = xw_q.rd;
  assign wb_data = xw_q.mem_re ? dcache_dout : xw_q.result;

  always_ff @(posedge clk) begin
    if (reset) begin
      csr <= '0;
    end else if (!stall && xw_q.csr_we) begin
      csr <= xw_q.result;
    end
  end

endmodule

// File: test/riscv_core_assert.sv
`timescale 1ns/1ns

module riscv_core_assert import rv_pkg::*; (
  input logic      clk,
  input logic      reset,
  input logic      stall,
  input xlen_t     icache_addr,
  input dmem_req_t dmem,
  input xlen_t     csr
);

  // Number of assertion failures so far.
  int n_fail = 0;

  // Only whole-word stores exist, so the byte enables move together.
  a_we_whole_word: assert property (@(posedge clk) disable iff (reset)
    (dmem.we == 4'h0) || (dmem.we == 4'hf))
    else begin
      n_fail = n_fail + 1;
      $error("data memory byte enables are partial: %h", dmem.we);
    end

  // A single memory request is either a load or a store.
  a_we_re_exclusive: assert property (@(posedge clk) disable iff (reset)
    !((|dmem.we) && dmem.re))
    else begin
      n_fail = n_fail + 1;
      $error("data memory read and write requested together");
    end

  // The fetch address is frozen while the pipeline is stalled.
  a_pc_holds: assert property (@(posedge clk) disable iff (reset)
    stall |=> $stable(icache_addr))
    else begin
      n_fail = n_fail + 1;
      $error("icache_addr moved during a stall");
    end

  // tohost is a pipeline register too and holds under stall.
  a_csr_holds: assert property (@(posedge clk) disable iff (reset)
    stall |=> $stable(csr))
    else begin
      n_fail = n_fail + 1;
      $error("csr changed during a stall");
    end

endmodule

bind riscv_core riscv_core_assert i_assert (
  .clk         (clk),
  .reset       (reset),
  .stall       (stall),
  .icache_addr (icache_addr),
  .dmem        (dmem),
  .csr         (csr)
);

// File: test/tb_riscv_core.sv
`timescale 1ns/1ns

module tb_riscv_core import rv_pkg::*; ();

  logic      clk;
  logic      reset;
  logic      stall;
  xlen_t     icache_addr;
  logic      icache_re;
  xlen_t     icache_dout;
  dmem_req_t dmem;
  xlen_t     dcache_dout;
  xlen_t     csr;

  // The program table holds each instruction, its tohost flag and the expected tohost value.
  xlen_t     prog_word [128];
  logic      prog_wr [128];
  xlen_t     prog_exp [128];
  int        n_rows;
  xlen_t     exp_q [$];
  xlen_t     imem [256];
  xlen_t     dmem_arr [64];
  int        seen;
  xlen_t     prev_csr;
  logic      stall_en;
  logic [31:0] rnd;

  riscv_core i_dut (
    .clk         (clk),
    .reset       (reset),
    .icache_addr (icache_addr),
    .icache_re   (icache_re),
    .icache_dout (icache_dout),
    .dmem        (dmem),
    .dcache_dout (dcache_dout),
    .stall       (stall),
    .csr         (csr)
  );

  always #5 clk = ~clk;

  function automatic logic [31:0] xorshift(logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // One instruction encoder for each RV32I format.
  function automatic xlen_t enc_r(logic [6:0] f7, reg_idx_t rs2, reg_idx_t rs1,
                                  logic [2:0] f3, reg_idx_t rd);
    return {f7, rs2, rs1, f3, rd, OP_REG};
  endfunction

  function automatic xlen_t enc_i(logic [11:0] imm, reg_idx_t rs1, logic [2:0] f3,
                                  reg_idx_t rd, logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic xlen_t enc_s(logic [11:0] imm, reg_idx_t rs2, reg_idx_t rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OP_STORE};
  endfunction

  function automatic xlen_t enc_b(logic [12:0] imm, reg_idx_t rs2, reg_idx_t rs1,
                                  logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BRANCH};
  endfunction

  function automatic xlen_t enc_j(logic [20:0] imm, reg_idx_t rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
  endfunction

  function automatic xlen_t tohost_reg(reg_idx_t rs);
    return enc_i(12'h51e, rs, 3'b001, 5'd0, OP_SYSTEM);
  endfunction

  function automatic xlen_t tohost_imm(logic [4:0] uimm);
    return enc_i(12'h51e, uimm, 3'b101, 5'd0, OP_SYSTEM);
  endfunction

  task automatic add_row(xlen_t word, logic wr, xlen_t exp_val);
    prog_word[n_rows] = word;
    prog_wr[n_rows]   = wr;
    prog_exp[n_rows]  = exp_val;
    n_rows++;
  endtask

  task automatic check(string name, xlen_t actual, xlen_t expected);
    if (actual !== expected) begin
      $display("mismatch at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
      $display("Test FAILED");
      $fatal(1, "value check failed");
    end
  endtask

  // A taken branch skips two marker writes of 31 while a not-taken one falls through.
  task automatic add_branch(logic [2:0] f3, reg_idx_t rs1, reg_idx_t rs2, logic taken,
                            logic [4:0] val);
    add_row(enc_b(13'd12, rs2, rs1, f3), 1'b0, '0);
    if (taken) begin
      add_row(tohost_imm(5'd31), 1'b0, '0);
      add_row(tohost_imm(5'd31), 1'b0, '0);
    end
    add_row(tohost_imm(val), 1'b1, {27'd0, val});
  endtask

  task automatic build_program();
    n_rows = 0;
    add_row(enc_i(12'd0, 5'd0, 3'b000, 5'd0, OP_IMM), 1'b0, '0);
    add_row(enc_i(12'd100, 5'd0, 3'b000, 5'd1, OP_IMM), 1'b0, '0);
    add_row(enc_i(12'hff9, 5'd0, 3'b000, 5'd2, OP_IMM), 1'b0, '0);
    // Each result goes to tohost in the very next slot.
    add_row(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd3), 1'b0, '0);
    add_row(tohost_reg(5'd3), 1'b1, 32'h0000_005d);
    add_row(enc_r(7'h20, 5'd2, 5'd1, 3'b000, 5'd4), 1'b0, '0);
    add_row(tohost_reg(5'd4), 1'b1, 32'h0000_006b);
    add_row(enc_r(7'h00, 5'd2, 5'd1, 3'b100, 5'd5), 1'b0, '0);
    add_row(tohost_reg(5'd5), 1'b1, 32'hffff_ff9d);
    add_row(enc_r(7'h00, 5'd2, 5'd1, 3'b111, 5'd6), 1'b0, '0);
    add_row(tohost_reg(5'd6), 1'b1, 32'h0000_0060);
    add_row(enc_r(7'h00, 5'd2, 5'd1, 3'b110, 5'd7), 1'b0, '0);
    add_row(tohost_reg(5'd7), 1'b1, 32'hffff_fffd);
    add_row(enc_r(7'h00, 5'd1, 5'd2, 3'b010, 5'd8), 1'b0, '0);
    add_row(tohost_reg(5'd8), 1'b1, 32'h0000_0001);
    add_row(enc_r(7'h00, 5'd1, 5'd2, 3'b011, 5'd9), 1'b0, '0);
    add_row(tohost_reg(5'd9), 1'b1, 32'h0000_0000);
    add_row(enc_i(12'd4, 5'd1, 3'b001, 5'd10, OP_IMM), 1'b0, '0);
    add_row(tohost_reg(5'd10), 1'b1, 32'h0000_0640);
    add_row(enc_i(12'h401, 5'd2, 3'b101, 5'd11, OP_IMM), 1'b0, '0);
    add_row(tohost_reg(5'd11), 1'b1, 32'hffff_fffc);
    add_row(enc_i(12'd28, 5'd2, 3'b101, 5'd12, OP_IMM), 1'b0, '0);
    add_row(tohost_reg(5'd12), 1'b1, 32'h0000_000f);
    add_row({20'h12345, 5'd13, OP_LUI}, 1'b0, '0);
    add_row(tohost_reg(5'd13), 1'b1, 32'h1234_5000);
    // auipc sits at word 25 at byte address 100.
    add_row({20'h00001, 5'd14, OP_AUIPC}, 1'b0, '0);
    add_row(tohost_reg(5'd14), 1'b1, 32'h0000_1064);
    // Store, load back at once and add a constant to the loaded word.
    add_row(enc_i(12'h040, 5'd0, 3'b000, 5'd15, OP_IMM), 1'b0, '0);
    add_row(enc_s(12'd0, 5'd13, 5'd15), 1'b0, '0);
    add_row(enc_i(12'd0, 5'd15, 3'b010, 5'd16, OP_LOAD), 1'b0, '0);
    add_row(enc_i(12'h055, 5'd16, 3'b000, 5'd17, OP_IMM), 1'b0, '0);
    add_row(tohost_reg(5'd17), 1'b1, 32'h1234_5055);
    // jal at word 32 links 0x84 and lands on word 35.
    add_row(enc_j(21'd12, 5'd18), 1'b0, '0);
    add_row(tohost_imm(5'd31), 1'b0, '0);
    add_row(tohost_imm(5'd31), 1'b0, '0);
    add_row(tohost_reg(5'd18), 1'b1, 32'h0000_0084);
    add_branch(3'b000, 5'd1, 5'd1, 1'b1, 5'd2);
    add_branch(3'b001, 5'd1, 5'd2, 1'b1, 5'd3);
    add_branch(3'b100, 5'd2, 5'd1, 1'b1, 5'd4);
    add_branch(3'b101, 5'd1, 5'd2, 1'b1, 5'd5);
    add_branch(3'b110, 5'd1, 5'd2, 1'b1, 5'd6);
    add_branch(3'b111, 5'd2, 5'd1, 1'b1, 5'd7);
    add_branch(3'b000, 5'd1, 5'd2, 1'b0, 5'd8);
    add_branch(3'b001, 5'd1, 5'd1, 1'b0, 5'd9);
    add_branch(3'b100, 5'd1, 5'd2, 1'b0, 5'd10);
    add_branch(3'b101, 5'd2, 5'd1, 1'b0, 5'd11);
    add_branch(3'b110, 5'd2, 5'd1, 1'b0, 5'd12);
    add_branch(3'b111, 5'd1, 5'd2, 1'b0, 5'd13);
    // jalr at word 73 links 0x128 and jumps to word 76 at 0x130.
    add_row(enc_i(12'd304, 5'd0, 3'b000, 5'd19, OP_IMM), 1'b0, '0);
    add_row(enc_i(12'd0, 5'd19, 3'b000, 5'd20, OP_JALR), 1'b0, '0);
    add_row(tohost_imm(5'd31), 1'b0, '0);
    add_row(tohost_imm(5'd31), 1'b0, '0);
    add_row(tohost_reg(5'd20), 1'b1, 32'h0000_0128);
    add_row(enc_j(21'd0, 5'd0), 1'b0, '0);
  endtask

  // The instruction memory is synchronous and freezes under stall.
  always @(posedge clk) begin
    if (!stall && icache_re) begin
      icache_dout <= imem[icache_addr[9:2]];
    end
  end

  // The data memory is synchronous and handles whole words only.
  always @(posedge clk) begin
    if (!stall) begin
      if (dmem.we == 4'hf) begin
        dmem_arr[dmem.addr[7:2]] <= dmem.din;
      end
      dcache_dout <= dmem_arr[dmem.addr[7:2]];
    end
  end

  // Stall is raised on random cycles in the second run only.
  always @(posedge clk) begin
    rnd <= xorshift(rnd);
    stall <= stall_en && !reset && (rnd[1:0] == 2'b00);
  end

  // Each change of tohost is matched against the next expected value.
  always @(negedge clk) begin
    if (reset) begin
      prev_csr = '0;
    end else if (csr !== prev_csr) begin
      if (seen >= exp_q.size()) begin
        $display("tohost was written again after the program had finished");
        $display("Test FAILED");
        $fatal(1, "unexpected tohost write");
      end else begin
        check("csr", csr, exp_q[seen]);
        seen++;
        prev_csr = csr;
      end
    end
  end

  // A failed assertion in the bound checker ends the run at once.
  always @(negedge clk) begin
    if (i_dut.i_assert.n_fail != 0) begin
      $display("A bound assertion on the core ports failed");
      $display("Test FAILED");
      $fatal(1, "assertion failed");
    end
  end

  initial begin
    #1;
    #((2 * (8 + n_rows * 8)) * 10);
    $display("Timed out before every tohost value was seen");
    $display("Test FAILED");
    $fatal(1, "watchdog expired");
  end

  initial begin
    clk         = 1'b0;
    reset       = 1'b1;
    stall       = 1'b0;
    stall_en    = 1'b0;
    icache_dout = '0;
    dcache_dout = '0;
    rnd         = 32'he133_9dc0;
    seen        = 0;
    prev_csr    = '0;
    build_program();
    // Unused words hold addi x0 with the word index as immediate.
    for (int i = 0; i < 256; i++) begin
      imem[i] = enc_i(12'(i), 5'd0, 3'b000, 5'd0, OP_IMM);
    end
    for (int i = 0; i < n_rows; i++) begin
      imem[i] = prog_word[i];
      if (prog_wr[i]) begin
        exp_q.push_back(prog_exp[i]);
      end
    end
    for (int run = 0; run < 2; run++) begin
      @(posedge clk);
      reset    <= 1'b1;
      stall_en <= (run == 1);
      for (int i = 0; i < 64; i++) begin
        dmem_arr[i] = 32'hdead_0000 | (i * 32'h0101);
      end
      repeat (7) @(posedge clk);
      @(negedge clk);
      check("icache_addr", icache_addr, PC_RESET);
      check("icache_re", {31'd0, icache_re}, 32'd0);
      check("dmem.we", {28'd0, dmem.we}, '0);
      check("dmem.re", {31'd0, dmem.re}, '0);
      check("csr", csr, '0);
      @(posedge clk);
      reset <= 1'b0;
      seen = 0;
      @(negedge clk);
      check("icache_addr", icache_addr, PC_RESET);
      check("icache_re", {31'd0, icache_re}, 32'd1);
      check("dmem.we", {28'd0, dmem.we}, '0);
      check("dmem.re", {31'd0, dmem.re}, '0);
      check("csr", csr, '0);
      wait (seen == exp_q.size());
      // Let the closing loop spin to catch any late write.
      repeat (20) @(posedge clk);
    end
    $display("Test OK");
    $finish;
  end

endmodule
